/* Bender.yml */
package:
  name: iosystem

sources:
  - io_pkg.sv
  - io_reg_if.sv
  - io_timer.sv
  - io_irq_ctrl.sv
  - io_watchdog.sv
  - io_gpio.sv
  - iosystem.sv
  - target: simulation
    files:
      - iosystem_properties.sv
      - tb_iosystem.sv

/* all.f */
io_pkg.sv
io_reg_if.sv
io_timer.sv
io_irq_ctrl.sv
io_watchdog.sv
io_gpio.sv
iosystem.sv
iosystem_properties.sv
tb_iosystem.sv

/* io_gpio.sv */
`timescale 1ns/1ps

module io_gpio
(
	input logic clk,
	input logic rst_n,
	io_reg_if.periph regs,
	inout tri logic [io_pkg::byte_w-1:0] pins
);

	logic [io_pkg::byte_w-1:0] ddr; // 1 makes the pin an output
	logic [io_pkg::byte_w-1:0] odr;
	logic [io_pkg::byte_w-1:0] pin_meta;
	logic [io_pkg::byte_w-1:0] idr;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			ddr <= '0;
			odr <= '0;
			pin_meta <= '0;
			idr <= '0;
		end
		else
		begin
			if (regs.wr_sel == io_pkg::sel_config && regs.wr_lane[0])
				ddr <= regs.wr_data[io_pkg::byte_w-1:0];
			if (regs.wr_sel == io_pkg::sel_counter && regs.wr_lane[0])
				odr <= regs.wr_data[io_pkg::byte_w-1:0];
			// two flop synchronizer, idr has no bus write path
			pin_meta <= pins;
			idr <= pin_meta;
		end
	end

	for (genvar i = 0; i < io_pkg::byte_w; i++)
	begin : g_pin
		assign pins[i] = ddr[i] ? odr[i] : 1'bz;
	end

	always_comb
	begin
		regs.rd_data = '0;
		case (regs.rd_sel)
			io_pkg::sel_config:
				regs.rd_data[io_pkg::byte_w-1:0] = ddr;
			io_pkg::sel_counter:
				regs.rd_data[io_pkg::byte_w-1:0] = odr;
			io_pkg::sel_reload:
				regs.rd_data[io_pkg::byte_w-1:0] = idr;
			default:
				regs.rd_data = '0;
		endcase
	end

endmodule

/* io_irq_ctrl.sv */
`timescale 1ns/1ps

module io_irq_ctrl
(
	input logic clk,
	input logic rst_n,
	io_reg_if.periph regs,
	input logic [io_pkg::num_irq-1:0] irq_in,
	output logic interrupt
);

	logic [io_pkg::num_irq-1:0] enable;
	logic [io_pkg::num_irq-1:0] active;
	logic [io_pkg::num_irq-1:0] clear;

	// write one to clear on the active register, low byte only
	assign clear = (regs.wr_sel == io_pkg::sel_counter && regs.wr_lane[0]) ?
		regs.wr_data[io_pkg::num_irq-1:0] : '0;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			enable <= '0;
			active <= '0;
		end
		else
		begin
			if (regs.wr_sel == io_pkg::sel_config && regs.wr_lane[0])
				enable <= regs.wr_data[io_pkg::num_irq-1:0];
			active <= (active & ~clear) | irq_in; // an incoming pulse beats the clear
		end
	end

	assign interrupt = |(active & enable);

	always_comb
	begin
		regs.rd_data = '0;
		if (regs.rd_sel == io_pkg::sel_config)
			regs.rd_data[io_pkg::num_irq-1:0] = enable;
		else if (regs.rd_sel == io_pkg::sel_counter)
			regs.rd_data[io_pkg::num_irq-1:0] = active;
	end

endmodule

/* io_patterns.txt */
# columns: test op a b c, numbers in hex
# wr rd rw rnd: a bank (0 even, 1 odd), b byte address, c data or count; drive pin: a value, b mask
regs wr 0 1C 34
regs wr 1 1C 12
regs rd 0 1C 34
regs rd 1 1C 12
regs wr 0 22 AB
regs wr 1 22 CD
regs rd 0 22 AB
regs rd 1 22 CD
regs wr 0 18 A4
regs rd 0 18 A4
regs rd 1 18 00
regs wr 0 18 00
regs wr 0 10 FF
regs rd 0 10 03
regs wr 0 10 00
regs wr 0 28 3C
regs wr 0 2A 96
regs rd 0 28 3C
regs rd 0 2A 96
regs wr 0 28 00
unmapped rd 0 40 00
unmapped rd 1 0C 00
forward rw 0 1E 5A
forward rw 1 1E C3
random rnd 0 1A 8
random rnd 1 1A 8
timer wr 0 1C 00
timer wr 1 1C FF
timer wr 0 1E F8
timer wr 1 1E FF
timer wr 0 1A F0
timer wr 1 1A FF
timer wr 0 18 01
timer rd 0 1A F0
timer rd 0 1A F1
timer wait 8 0 0
timer rd 0 12 02
timer wait 8 0 0
timer wr 0 18 00
timer rd 0 12 03
timer rd 0 1A 04
timer rd 1 1A FF
irq irq 0 0 0
irq wr 0 10 02
irq irq 1 0 0
irq wr 0 12 02
irq irq 0 0 0
irq wr 0 10 03
irq irq 1 0 0
irq wr 0 12 03
irq irq 0 0 0
irq wr 0 10 00
wdt wr 0 22 05
wdt wr 1 22 00
wdt wr 0 20 01
wdt rst 7 0 0
wdt wr 0 00 00
wdt quiet 3 0 0
wdt wr 0 00 00
wdt quiet 3 0 0
wdt wr 0 00 00
wdt quiet 3 0 0
wdt wr 0 20 00
trap trap 0 0 0
trap rst 1 0 0
trap quiet 3 0 0
gpio wr 0 28 0F
gpio wr 0 2A A5
gpio drive C0 F0 0
gpio pin 05 0F 0
gpio wait 2 0 0
gpio rd 0 2C C5
gpio drive 00 00 0
gpio wr 0 28 00

/* io_pkg.sv */
package io_pkg;

	// bus widths
	localparam int addr_w = 15;
	localparam int byte_w = 8;
	localparam int reg_w = 16;

	// interrupt sources and their position in the interrupt vector
	localparam int num_irq = 2;
	localparam int irq_overflow = 0;
	localparam int irq_compare = 1;

	// byte address map, the word address on each bank is half of these
	localparam logic [15:0] wdt_kick_addr = 16'h0000;
	localparam logic [15:0] irq_enable_addr = 16'h0010;
	localparam logic [15:0] irq_active_addr = 16'h0012;
	localparam logic [15:0] timer_config_addr = 16'h0018;
	localparam logic [15:0] timer_counter_addr = 16'h001A;
	localparam logic [15:0] timer_reload_addr = 16'h001C;
	localparam logic [15:0] timer_compare_addr = 16'h001E;
	localparam logic [15:0] wdt_config_addr = 16'h0020;
	localparam logic [15:0] wdt_timeout_addr = 16'h0022;
	localparam logic [15:0] gpio_ddr_addr = 16'h0028;
	localparam logic [15:0] gpio_odr_addr = 16'h002A;
	localparam logic [15:0] gpio_idr_addr = 16'h002C;

	// register within a peripheral, gpio and irq controller reuse the first codes
	typedef enum logic [1:0] {sel_config, sel_counter, sel_reload, sel_compare} reg_sel_t;

	localparam int cfg_enable = 0; // enable bit in timer and watchdog config

	// replace only the bytes whose lane strobe is high
	function automatic logic [reg_w-1:0] lane_merge(input logic [reg_w-1:0] old_val,
		input logic [1:0] lane, input logic [reg_w-1:0] new_val);
		lane_merge = old_val;
		if (lane[0])
			lane_merge[byte_w-1:0] = new_val[byte_w-1:0];
		if (lane[1])
			lane_merge[reg_w-1:byte_w] = new_val[reg_w-1:byte_w];
	endfunction

endpackage

/* io_reg_if.sv */
`timescale 1ns/1ps

// register access port of one peripheral
interface io_reg_if;

	logic [1:0] wr_lane; // bit 0 is the even low byte, bit 1 the odd high byte
	io_pkg::reg_sel_t wr_sel;
	logic [io_pkg::reg_w-1:0] wr_data;
	io_pkg::reg_sel_t rd_sel;
	logic [io_pkg::reg_w-1:0] rd_data; // combinational from rd_sel

	modport bus
	(
		output wr_lane, wr_sel, wr_data, rd_sel,
		input rd_data
	);

	modport periph
	(
		input wr_lane, wr_sel, wr_data, rd_sel,
		output rd_data
	);

endinterface

/* io_timer.sv */
`timescale 1ns/1ps

module io_timer
(
	input logic clk,
	input logic rst_n,
	io_reg_if.periph regs,
	output logic overflow_irq,
	output logic compare_irq
);

	logic [io_pkg::byte_w-1:0] cfg;
	logic [io_pkg::reg_w-1:0] counter;
	logic [io_pkg::reg_w-1:0] reload;
	logic [io_pkg::reg_w-1:0] compare;
	logic running;
	logic counter_wr;

	assign running = cfg[io_pkg::cfg_enable];
	// a bus write to the counter overrides counting in that cycle
	assign counter_wr = (regs.wr_sel == io_pkg::sel_counter) && (|regs.wr_lane);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			cfg <= '0;
			counter <= '0;
			reload <= '0;
			compare <= '0;
			overflow_irq <= 1'b0;
			compare_irq <= 1'b0;
		end
		else
		begin
			if (regs.wr_sel == io_pkg::sel_config && regs.wr_lane[0])
				cfg <= regs.wr_data[io_pkg::byte_w-1:0]; // config is a single byte
			if (regs.wr_sel == io_pkg::sel_reload)
				reload <= io_pkg::lane_merge(reload, regs.wr_lane, regs.wr_data);
			if (regs.wr_sel == io_pkg::sel_compare)
				compare <= io_pkg::lane_merge(compare, regs.wr_lane, regs.wr_data);

			if (counter_wr)
				counter <= io_pkg::lane_merge(counter, regs.wr_lane, regs.wr_data);
			else if (running)
				counter <= (counter == '1) ? reload : counter + 1'b1; // wrap loads reload

			// both pulses last one cycle, the counter never holds a value twice while running
			overflow_irq <= running && !counter_wr && (counter == '1);
			compare_irq <= running && (counter == compare);
		end
	end

	always_comb
	begin
		case (regs.rd_sel)
			io_pkg::sel_config:
				regs.rd_data = {{(io_pkg::reg_w - io_pkg::byte_w){1'b0}}, cfg};
			io_pkg::sel_counter:
				regs.rd_data = counter;
			io_pkg::sel_reload:
				regs.rd_data = reload;
			default:
				regs.rd_data = compare;
		endcase
	end

endmodule

/* io_watchdog.sv */
`timescale 1ns/1ps

module io_watchdog
(
	input logic clk,
	input logic rst_n,
	input logic kick,
	input logic trap,
	io_reg_if.periph regs,
	output logic reset
);

	logic [io_pkg::byte_w-1:0] cfg;
	logic [io_pkg::reg_w-1:0] timeout;
	logic [io_pkg::reg_w-1:0] counter;
	logic cfg_wr;
	logic running;
	logic start;
	logic expire;

	assign cfg_wr = (regs.wr_sel == io_pkg::sel_config) && regs.wr_lane[0];
	assign running = cfg[io_pkg::cfg_enable];
	// rising enable seen at the config write itself, so the load happens at that edge
	assign start = cfg_wr && regs.wr_data[io_pkg::cfg_enable] && !running;
	assign expire = running && !kick && (counter == '0);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			cfg <= '0;
			timeout <= '0;
			counter <= '0;
			reset <= 1'b0;
		end
		else
		begin
			if (cfg_wr)
				cfg <= regs.wr_data[io_pkg::byte_w-1:0];
			if (regs.wr_sel == io_pkg::sel_reload)
				timeout <= io_pkg::lane_merge(timeout, regs.wr_lane, regs.wr_data);

			if (start || (running && kick))
				counter <= timeout;
			else if (running)
				counter <= expire ? timeout : counter - 1'b1;

			// a pulse is never stretched, even with a zero timeout or a held trap
			reset <= (expire || trap) && !reset;
		end
	end

	always_comb
	begin
		case (regs.rd_sel)
			io_pkg::sel_config:
				regs.rd_data = {{(io_pkg::reg_w - io_pkg::byte_w){1'b0}}, cfg};
			io_pkg::sel_counter:
				regs.rd_data = counter; // running count, not mapped on the bus
			io_pkg::sel_reload:
				regs.rd_data = timeout;
			default:
				regs.rd_data = '0;
		endcase
	end

endmodule

/* iosystem.sv */
`timescale 1ns/1ps

module iosystem
(
	input logic clk,
	input logic rst_n,
	input logic [io_pkg::addr_w-1:0] read_addr_even,
	input logic [io_pkg::addr_w-1:0] write_addr_even,
	input logic [io_pkg::addr_w-1:0] read_addr_odd,
	input logic [io_pkg::addr_w-1:0] write_addr_odd,
	input logic [io_pkg::byte_w-1:0] write_data_even,
	input logic [io_pkg::byte_w-1:0] write_data_odd,
	input logic write_en_even,
	input logic write_en_odd,
	input logic trap,
	output logic [io_pkg::byte_w-1:0] read_data_even,
	output logic [io_pkg::byte_w-1:0] read_data_odd,
	output logic interrupt,
	output logic reset,
	inout tri logic [io_pkg::byte_w-1:0] gpio_pins
);

	typedef enum logic [2:0] {dev_none, dev_irq, dev_timer, dev_wdt, dev_gpio} dev_t;
	typedef struct packed {
		dev_t dev;
		io_pkg::reg_sel_t sel;
	} map_t;

	// word address to peripheral and register, the same word on both banks
	function automatic map_t decode(input logic [io_pkg::addr_w-1:0] word);
		map_t m;
		m = '{dev_none, io_pkg::sel_config};
		case (word)
			io_pkg::irq_enable_addr / 2: m = '{dev_irq, io_pkg::sel_config};
			io_pkg::irq_active_addr / 2: m = '{dev_irq, io_pkg::sel_counter};
			io_pkg::timer_config_addr / 2: m = '{dev_timer, io_pkg::sel_config};
			io_pkg::timer_counter_addr / 2: m = '{dev_timer, io_pkg::sel_counter};
			io_pkg::timer_reload_addr / 2: m = '{dev_timer, io_pkg::sel_reload};
			io_pkg::timer_compare_addr / 2: m = '{dev_timer, io_pkg::sel_compare};
			io_pkg::wdt_config_addr / 2: m = '{dev_wdt, io_pkg::sel_config};
			io_pkg::wdt_timeout_addr / 2: m = '{dev_wdt, io_pkg::sel_reload};
			io_pkg::gpio_ddr_addr / 2: m = '{dev_gpio, io_pkg::sel_config};
			io_pkg::gpio_odr_addr / 2: m = '{dev_gpio, io_pkg::sel_counter};
			io_pkg::gpio_idr_addr / 2: m = '{dev_gpio, io_pkg::sel_reload};
			default: m = '{dev_none, io_pkg::sel_config};
		endcase
		return m;
	endfunction

	map_t wr_even_m, wr_odd_m, rd_even_m, rd_odd_m;
	logic [io_pkg::reg_w-1:0] rd_word [0:4]; // indexed by dev_t, entry 0 reads as zero
	logic wdt_kick;
	logic timer_ovf, timer_cmp;
	logic [io_pkg::num_irq-1:0] irq_vec;

	assign wr_even_m = decode(write_addr_even);
	assign wr_odd_m = decode(write_addr_odd);
	assign rd_even_m = decode(read_addr_even);
	assign rd_odd_m = decode(read_addr_odd);
	assign rd_word[0] = '0;
	assign wdt_kick = write_en_even && (write_addr_even == io_pkg::wdt_kick_addr / 2);

	io_reg_if bus [1:4] ();

	// one register select per peripheral, so the even bank wins when both banks hit
	// different registers of the same peripheral in one cycle
	for (genvar d = 1; d <= 4; d++)
	begin : g_route
		logic even_wr, odd_wr;
		assign even_wr = write_en_even && (wr_even_m.dev == dev_t'(d));
		assign odd_wr = write_en_odd && (wr_odd_m.dev == dev_t'(d));
		assign bus[d].wr_sel = even_wr ? wr_even_m.sel : wr_odd_m.sel;
		assign bus[d].wr_lane = {odd_wr && (!even_wr || wr_odd_m.sel == wr_even_m.sel), even_wr};
		assign bus[d].wr_data = {write_data_odd, write_data_even};
		assign bus[d].rd_sel = (rd_even_m.dev == dev_t'(d)) ? rd_even_m.sel : rd_odd_m.sel;
		assign rd_word[d] = bus[d].rd_data;
	end

	always_comb
	begin
		irq_vec = '0;
		irq_vec[io_pkg::irq_overflow] = timer_ovf;
		irq_vec[io_pkg::irq_compare] = timer_cmp;
	end

	io_irq_ctrl u_irq (.clk, .rst_n, .regs(bus[dev_irq]), .irq_in(irq_vec), .interrupt);
	io_timer u_timer (.clk, .rst_n, .regs(bus[dev_timer]), .overflow_irq(timer_ovf),
		.compare_irq(timer_cmp));
	io_watchdog u_wdt (.clk, .rst_n, .kick(wdt_kick), .trap, .regs(bus[dev_wdt]), .reset);
	io_gpio u_gpio (.clk, .rst_n, .regs(bus[dev_gpio]), .pins(gpio_pins));

	// registered read return, a same-cycle write to the read address is forwarded
	always_ff @(posedge clk)
	begin
		if (write_en_even && read_addr_even == write_addr_even)
			read_data_even <= write_data_even;
		else
			read_data_even <= rd_word[rd_even_m.dev][io_pkg::byte_w-1:0];

		if (write_en_odd && read_addr_odd == write_addr_odd)
			read_data_odd <= write_data_odd;
		else
			read_data_odd <= rd_word[rd_odd_m.dev][io_pkg::reg_w-1:io_pkg::byte_w];
	end

endmodule

/* iosystem_properties.sv */
`timescale 1ns/1ps

module iosystem_properties
(
	input logic clk,
	input logic rst_n,
	input logic interrupt,
	input logic reset
);

	int error_count = 0; // number of property failures so far

	// registers are cleared at a reset edge, so both outputs are low one cycle later
	outputs_low_after_reset: assert property (@(posedge clk) !rst_n |=> !interrupt && !reset)
		else
		begin
			error_count++;
			$error("interrupt or reset is high in the cycle after rst_n was low");
		end

	reset_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		reset |=> !reset)
		else
		begin
			error_count++;
			$error("reset to the processor stayed high for two cycles");
		end

	interrupt_known: assert property (@(posedge clk) disable iff (!rst_n)
		!$isunknown(interrupt))
		else
		begin
			error_count++;
			$error("interrupt line is unknown after reset");
		end

endmodule

bind iosystem iosystem_properties u_properties (.clk, .rst_n, .interrupt, .reset);

/* tb_iosystem.sv */
`timescale 1ns/1ps

module tb_iosystem;

	localparam int half_period = 5;
	localparam int reset_cycles = 16;
	localparam int drive_delay = 1;
	localparam logic [31:0] seed = 32'h402f;
	localparam int timeout_margin = 200;
	localparam string pattern_file = "io_patterns.txt";

	logic clk;
	logic rst_n;
	logic [io_pkg::addr_w-1:0] read_addr_even, write_addr_even;
	logic [io_pkg::addr_w-1:0] read_addr_odd, write_addr_odd;
	logic [io_pkg::byte_w-1:0] write_data_even, write_data_odd;
	logic write_en_even, write_en_odd, trap;
	logic [io_pkg::byte_w-1:0] read_data_even, read_data_odd;
	logic interrupt, reset;
	tri logic [io_pkg::byte_w-1:0] gpio_pins;
	logic [io_pkg::byte_w-1:0] pin_value;
	logic [io_pkg::byte_w-1:0] pin_mask; // 1 where the testbench drives the pin
	int cycle_count = 0;
	int cycle_limit = 0;

	iosystem dut (.clk, .rst_n, .read_addr_even, .write_addr_even, .read_addr_odd,
		.write_addr_odd, .write_data_even, .write_data_odd, .write_en_even, .write_en_odd,
		.trap, .read_data_even, .read_data_odd, .interrupt, .reset, .gpio_pins);

	for (genvar i = 0; i < io_pkg::byte_w; i++)
	begin : g_pin_drive
		assign gpio_pins[i] = pin_mask[i] ? pin_value[i] : 1'bz;
	end

	always #half_period clk = ~clk;

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit > 0 && cycle_count >= cycle_limit)
			stop_with_failure($sformatf("timeout, the run did not end within %0d cycles",
				cycle_limit));
	end

	// the bound properties on interrupt and reset end the run at their first failure
	always @(dut.u_properties.error_count)
	begin
		if (dut.u_properties.error_count != 0)
			stop_with_failure("a bound property on the interrupt or reset output failed");
	end

	task automatic stop_with_failure(input string msg);
		$display("%s", msg);
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	// inputs change a little after the edge so the DUT samples settled values
	task automatic step_clock();
		@(posedge clk);
		#drive_delay;
	endtask

	task automatic check_byte(input logic [8*24-1:0] name, input logic [7:0] expected,
		input logic [7:0] actual);
		assert (actual === expected)
		else
			stop_with_failure($sformatf("[FAIL] %0s expected %02h actual %02h",
				name, expected, actual));
	endtask

	task automatic write_byte(input logic bank, input logic [15:0] addr, input logic [7:0] data);
		if (bank)
		begin
			write_addr_odd = addr[15:1];
			write_data_odd = data;
			write_en_odd = 1'b1;
		end
		else
		begin
			write_addr_even = addr[15:1];
			write_data_even = data;
			write_en_even = 1'b1;
		end
		step_clock();
		write_en_even = 1'b0;
		write_en_odd = 1'b0;
	endtask

	// read data is registered, so it is checked one edge after the address
	task automatic read_expect(input logic [8*24-1:0] name, input logic bank,
		input logic [15:0] addr, input logic [7:0] expected);
		if (bank)
			read_addr_odd = addr[15:1];
		else
			read_addr_even = addr[15:1];
		step_clock();
		check_byte(name, expected, bank ? read_data_odd : read_data_even);
	endtask

	task automatic write_read_same(input logic [8*24-1:0] name, input logic bank,
		input logic [15:0] addr, input logic [7:0] data);
		if (bank)
			read_addr_odd = addr[15:1];
		else
			read_addr_even = addr[15:1];
		write_byte(bank, addr, data); // the read address is already in place
		check_byte(name, data, bank ? read_data_odd : read_data_even);
	endtask

	task automatic random_readback(input logic [8*24-1:0] name, input logic bank,
		input logic [15:0] addr, input int count);
		logic [7:0] value;
		for (int i = 0; i < count; i++)
		begin
			value = $urandom % 256;
			write_byte(bank, addr, value);
			read_expect(name, bank, addr, value);
		end
	endtask

	task automatic expect_reset_pulse(input logic [8*24-1:0] name, input int limit);
		bit seen = 1'b0;
		for (int i = 0; i <= limit && !seen; i++)
		begin
			if (reset === 1'b1)
				seen = 1'b1;
			else if (i < limit)
				step_clock();
		end
		assert (seen)
		else
			stop_with_failure($sformatf("%0s: no reset pulse came within %0d cycles",
				name, limit));
	endtask

	task automatic hold_reset_low(input logic [8*24-1:0] name, input int cycles);
		repeat (cycles)
		begin
			step_clock();
			assert (reset === 1'b0)
			else
				stop_with_failure($sformatf("[FAIL] %0s expected reset 0 actual %b",
					name, reset));
		end
	endtask

	task automatic pulse_trap();
		trap = 1'b1;
		step_clock();
		trap = 1'b0;
	endtask

	// next operation line, lines whose first token is # are skipped
	task automatic next_operation(input int fd, output bit got, output logic [8*24-1:0] name,
		output logic [8*8-1:0] op, output logic [31:0] a, b, c);
		logic [8*128-1:0] rest;
		int code;
		got = 1'b0;
		while (!got && !$feof(fd))
		begin
			code = $fscanf(fd, "%s", name);
			if (code == 1 && name == "#")
				code = $fgets(rest, fd);
			else if (code == 1)
			begin
				code = $fscanf(fd, "%s %h %h %h", op, a, b, c);
				if (code != 4)
					stop_with_failure($sformatf("malformed pattern line in test %0s", name));
				got = 1'b1;
			end
		end
	endtask

	task automatic open_patterns(output int fd);
		fd = $fopen(pattern_file, "r");
		if (fd == 0)
			stop_with_failure("cannot open the pattern file io_patterns.txt");
	endtask

	// every line takes about one cycle, waits and loops add their own length
	task automatic count_cycle_budget(output int limit);
		int fd;
		bit got;
		logic [8*24-1:0] name;
		logic [8*8-1:0] op;
		logic [31:0] a, b, c;
		int lines = 0;
		int waits = 0;
		open_patterns(fd);
		do
		begin
			next_operation(fd, got, name, op, a, b, c);
			if (got)
			begin
				lines++;
				if (op == "wait" || op == "rst" || op == "quiet")
					waits += a;
				else if (op == "rnd")
					waits += 2 * c;
			end
		end
		while (got);
		$fclose(fd);
		limit = waits + lines + timeout_margin;
	endtask

	task automatic run_operation(input logic [8*24-1:0] name, input logic [8*8-1:0] op,
		input logic [31:0] a, b, c);
		case (op)
			"wr": write_byte(a[0], b[15:0], c[7:0]);
			"rd": read_expect(name, a[0], b[15:0], c[7:0]);
			"rw": write_read_same(name, a[0], b[15:0], c[7:0]);
			"rnd": random_readback(name, a[0], b[15:0], c);
			"drive":
			begin
				pin_value = a[7:0];
				pin_mask = b[7:0];
			end
			"pin": check_byte(name, a[7:0], gpio_pins & b[7:0]);
			"wait": repeat (a) step_clock();
			"irq":
				assert (interrupt === a[0])
				else
					stop_with_failure($sformatf("[FAIL] %0s expected interrupt %b actual %b",
						name, a[0], interrupt));
			"rst": expect_reset_pulse(name, a);
			"quiet": hold_reset_low(name, a);
			"trap": pulse_trap();
			default: stop_with_failure($sformatf("unknown operation %0s in test %0s", op, name));
		endcase
	endtask

	initial
	begin
		int fd;
		bit got;
		logic [8*24-1:0] name;
		logic [8*8-1:0] op;
		logic [31:0] a, b, c;
		clk = 1'b0;
		rst_n = 1'b0;
		read_addr_even = '0;
		write_addr_even = '0;
		read_addr_odd = '0;
		write_addr_odd = '0;
		write_data_even = '0;
		write_data_odd = '0;
		write_en_even = 1'b0;
		write_en_odd = 1'b0;
		trap = 1'b0;
		pin_value = '0;
		pin_mask = '0;
		void'($urandom(seed)); // seeds the generator for the whole run
		count_cycle_budget(cycle_limit);
		repeat (reset_cycles) step_clock();
		rst_n = 1'b1;
		open_patterns(fd);
		do
		begin
			next_operation(fd, got, name, op, a, b, c);
			if (got)
				run_operation(name, op, a, b, c);
		end
		while (got);
		$fclose(fd);
		$display("PASS: all tests");
		$finish;
	end

endmodule
